//--- src/trace_isa_pkg.sv
package trace_isa_pkg;

  ////////////////////////////////////////
  // rv32i major opcodes
  ////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // class reported on the trace port
  typedef enum logic [3:0] {
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_OP_IMM,
    CLS_OP,
    CLS_FENCE,
    CLS_CSR,
    CLS_SYSTEM,
    CLS_INVALID
  } instr_class_e;

  ////////////////////////////////////////
  // instruction field positions
  ////////////////////////////////////////

  localparam logic [4:0] RD_LSB     = 5'd7;
  localparam logic [4:0] FUNCT3_LSB = 5'd12;
  localparam logic [4:0] RS1_LSB    = 5'd15;
  localparam logic [4:0] FUNCT7_LSB = 5'd25;
  localparam logic [4:0] REG_ADDR_W = 5'd5;

endpackage

//--- src/trace_pipe_pkg.sv
package trace_pipe_pkg;

  ////////////////////////////////////////
  // tracer slot bookkeeping
  ////////////////////////////////////////

  // SLOT_DONE marks a bypass record that retires without wb sampling
  typedef enum logic [1:0] {
    SLOT_EMPTY = 2'b00,
    SLOT_WAIT  = 2'b01,
    SLOT_DONE  = 2'b10
  } slot_state_e;

  // defaults for the top level parameters
  localparam int unsigned DEF_XLEN    = 32;
  localparam int unsigned DEF_CYCLE_W = 32;

endpackage

//--- src/instr_classifier.sv
module instr_classifier import trace_isa_pkg::*; (
  input  logic [31:0]           instr,
  output instr_class_e          instr_class,
  output logic                  rd_wr,
  output logic [REG_ADDR_W-1:0] rd
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       writes_rd;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[FUNCT3_LSB +: 3];
  assign funct7 = instr[FUNCT7_LSB +: 7];
  assign rd     = instr[RD_LSB +: REG_ADDR_W];

  // major opcode first, then the funct fields that rv32i leaves reserved
  always_comb begin
    instr_class = CLS_INVALID;
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        OPC_LUI:      instr_class = CLS_LUI;
        OPC_AUIPC:    instr_class = CLS_AUIPC;
        OPC_JAL:      instr_class = CLS_JAL;
        OPC_JALR:     instr_class = CLS_JALR;
        OPC_MISC_MEM: instr_class = CLS_FENCE;
        OPC_BRANCH: begin
          if (funct3 != 3'b010 && funct3 != 3'b011) instr_class = CLS_BRANCH;
        end
        OPC_LOAD: begin
          if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) instr_class = CLS_LOAD;
        end
        OPC_STORE: begin
          if (funct3 < 3'b011) instr_class = CLS_STORE;
        end
        OPC_OP_IMM: begin
          // slli, srli, srai carry a shamt, the rest a full immediate
          if (funct3 == 3'b001) begin
            if (funct7 == 7'b0000000) instr_class = CLS_OP_IMM;
          end else if (funct3 == 3'b101) begin
            if (funct7 == 7'b0000000 || funct7 == 7'b0100000) instr_class = CLS_OP_IMM;
          end else begin
            instr_class = CLS_OP_IMM;
          end
        end
        OPC_OP: begin
          // only sub and sra use the alternate funct7
          if (funct7 == 7'b0000000 ||
              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
            instr_class = CLS_OP;
          end
        end
        OPC_SYSTEM: begin
          if (funct3 == 3'b000) instr_class = CLS_SYSTEM;
          else if (funct3 != 3'b100) instr_class = CLS_CSR;
        end
        default: instr_class = CLS_INVALID;
      endcase
    end
  end

  always_comb begin
    case (instr_class)
      CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
      CLS_OP_IMM, CLS_OP, CLS_LOAD, CLS_CSR: writes_rd = 1'b1;
      default:                               writes_rd = 1'b0;
    endcase
  end

  // x0 writes are never traced
  assign rd_wr = writes_rd && (rd != '0);

endmodule

//--- src/trace_ctrl.sv
module trace_ctrl import trace_pipe_pkg::*; #(
  parameter int unsigned CYCLE_W = DEF_CYCLE_W
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               id_valid,
  input  logic               is_decoding,
  input  logic               pipe_flush,
  input  logic               ex_valid,
  input  logic               wb_bypass,
  input  logic               wb_valid,
  output logic               capture,
  output logic               ex_busy,
  output logic               ex_leave,
  output logic               wb_busy,
  output logic               wb_retire,
  output slot_state_e        wb_state,
  output logic [CYCLE_W-1:0] cycle
);

  ////////////////////////////////////////
  // stage move strobes
  ////////////////////////////////////////

  // a flush also retires the instruction sitting in decode
  assign capture   = (id_valid && is_decoding) || pipe_flush;
  assign ex_leave  = ex_busy && (ex_valid || wb_bypass);
  assign wb_busy   = (wb_state != SLOT_EMPTY);
  assign wb_retire = ((wb_state == SLOT_WAIT) && wb_valid) || (wb_state == SLOT_DONE);

  ////////////////////////////////////////
  // cycle counter and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle <= '0;
    end else begin
      cycle <= cycle + 1'b1;
    end
  end

  // a new capture may follow an ex leave on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_busy <= 1'b0;
    end else if (capture) begin
      ex_busy <= 1'b1;
    end else if (ex_leave) begin
      ex_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_state <= SLOT_EMPTY;
    end else if (ex_leave) begin
      wb_state <= wb_bypass ? SLOT_DONE : SLOT_WAIT;
    end else if (wb_retire) begin
      wb_state <= SLOT_EMPTY;
    end
  end

  // no room for a second record in either stage
  a_ex_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    capture && ex_busy |-> ex_leave)
    else $error("capture into an occupied EX slot");

  a_wb_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    ex_leave && wb_busy |-> wb_retire)
    else $error("EX record moved into an occupied WB slot");

  // a bypassed record must not be retired a second time by wb_valid
  a_bypass_once: assert property (@(posedge clk) disable iff (!rst_n)
    ex_leave && wb_bypass |=> !wb_valid)
    else $error("wb_valid seen for a record that bypassed WB");

endmodule

//--- src/ex_stage_slot.sv
module ex_stage_slot import trace_isa_pkg::*, trace_pipe_pkg::*; #(
  parameter int unsigned XLEN    = DEF_XLEN,
  parameter int unsigned CYCLE_W = DEF_CYCLE_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  capture,
  input  logic                  ex_busy,
  input  logic [XLEN-1:0]       pc,
  input  logic [31:0]           instr,
  input  instr_class_e          instr_class,
  input  logic                  rd_wr,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic [CYCLE_W-1:0]    cycle,
  input  logic [REG_ADDR_W-1:0] ex_reg_addr,
  input  logic                  ex_reg_we,
  input  logic [XLEN-1:0]       ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic [XLEN-1:0]       ex_data_addr,
  input  logic                  ex_data_we,
  output logic [XLEN-1:0]       rec_pc,
  output logic [31:0]           rec_instr,
  output instr_class_e          rec_class,
  output logic [CYCLE_W-1:0]    rec_cycle,
  output logic [REG_ADDR_W-1:0] rec_rd,
  output logic                  rec_rd_wr,
  output logic [XLEN-1:0]       rec_rd_val,
  output logic                  rec_rd_seen,
  output logic                  rec_mem_seen,
  output logic [XLEN-1:0]       rec_mem_addr,
  output logic                  rec_mem_we
);

  logic            rd_hit;
  logic            mem_hit;
  logic [XLEN-1:0] rd_val_q;
  logic            rd_seen_q;
  logic            mem_seen_q;
  logic [XLEN-1:0] mem_addr_q;
  logic            mem_we_q;

  assign rd_hit  = ex_busy && ex_reg_we && (ex_reg_addr == rec_rd);
  assign mem_hit = ex_busy && !mem_seen_q && ex_data_req && ex_data_gnt;

  // record as seen after this edge, so a leaving record includes the current sample
  assign rec_rd_val   = rd_hit ? ex_reg_wdata : rd_val_q;
  assign rec_rd_seen  = rd_seen_q || rd_hit;
  assign rec_mem_seen = mem_seen_q || mem_hit;
  assign rec_mem_addr = mem_hit ? ex_data_addr : mem_addr_q;
  assign rec_mem_we   = mem_hit ? ex_data_we : mem_we_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_seen_q  <= 1'b0;
      mem_seen_q <= 1'b0;
    end else if (capture) begin
      rd_seen_q  <= 1'b0;
      mem_seen_q <= 1'b0;
    end else begin
      rd_seen_q  <= rec_rd_seen;
      mem_seen_q <= rec_mem_seen;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rec_pc    <= pc;
      rec_instr <= instr;
      rec_class <= instr_class;
      rec_cycle <= cycle;
      rec_rd    <= rd;
      rec_rd_wr <= rd_wr;
    end
    rd_val_q   <= rec_rd_val;
    mem_addr_q <= rec_mem_addr;
    mem_we_q   <= rec_mem_we;
  end

  a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    ex_busy && ex_data_gnt |-> ex_data_req)
    else $error("data grant without a request");

endmodule

//--- src/wb_stage_slot.sv
module wb_stage_slot import trace_isa_pkg::*, trace_pipe_pkg::*; #(
  parameter int unsigned XLEN    = DEF_XLEN,
  parameter int unsigned CYCLE_W = DEF_CYCLE_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_leave,
  input  slot_state_e           wb_state,
  input  logic                  wb_retire,
  input  logic [XLEN-1:0]       rec_pc,
  input  logic [31:0]           rec_instr,
  input  instr_class_e          rec_class,
  input  logic [CYCLE_W-1:0]    rec_cycle,
  input  logic [REG_ADDR_W-1:0] rec_rd,
  input  logic                  rec_rd_wr,
  input  logic [XLEN-1:0]       rec_rd_val,
  input  logic                  rec_rd_seen,
  input  logic                  rec_mem_seen,
  input  logic [XLEN-1:0]       rec_mem_addr,
  input  logic                  rec_mem_we,
  input  logic [REG_ADDR_W-1:0] wb_reg_addr,
  input  logic                  wb_reg_we,
  input  logic [XLEN-1:0]       wb_reg_wdata,
  output logic                  trace_valid,
  output logic [XLEN-1:0]       trace_pc,
  output logic [31:0]           trace_instr,
  output instr_class_e          trace_class,
  output logic [CYCLE_W-1:0]    trace_cycle,
  output logic [REG_ADDR_W-1:0] trace_rd,
  output logic                  trace_rd_valid,
  output logic [XLEN-1:0]       trace_rd_wdata,
  output logic                  trace_mem_valid,
  output logic [XLEN-1:0]       trace_mem_addr,
  output logic                  trace_mem_we
);

  logic [XLEN-1:0]       pc_q;
  logic [31:0]           instr_q;
  instr_class_e          class_q;
  logic [CYCLE_W-1:0]    cycle_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic                  rd_wr_q;
  logic [XLEN-1:0]       rd_val_q;
  logic                  rd_seen_q;
  logic                  mem_seen_q;
  logic [XLEN-1:0]       mem_addr_q;
  logic                  mem_we_q;
  logic                  rd_hit;
  logic [XLEN-1:0]       rd_val;
  logic                  rd_seen;

  // bypass records (SLOT_DONE) never take wb writes
  assign rd_hit  = (wb_state == SLOT_WAIT) && wb_reg_we && (wb_reg_addr == rd_q);
  assign rd_val  = rd_hit ? wb_reg_wdata : rd_val_q;
  assign rd_seen = rd_seen_q || rd_hit;

  always_ff @(posedge clk) begin
    if (ex_leave) begin
      pc_q       <= rec_pc;
      instr_q    <= rec_instr;
      class_q    <= rec_class;
      cycle_q    <= rec_cycle;
      rd_q       <= rec_rd;
      rd_wr_q    <= rec_rd_wr;
      rd_val_q   <= rec_rd_val;
      rd_seen_q  <= rec_rd_seen;
      mem_seen_q <= rec_mem_seen;
      mem_addr_q <= rec_mem_addr;
      mem_we_q   <= rec_mem_we;
    end else begin
      rd_val_q  <= rd_val;
      rd_seen_q <= rd_seen;
    end
  end

  ////////////////////////////////////////
  // trace output registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= wb_retire;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_retire) begin
      trace_pc        <= pc_q;
      trace_instr     <= instr_q;
      trace_class     <= class_q;
      trace_cycle     <= cycle_q;
      trace_rd        <= rd_q;
      trace_rd_valid  <= rd_wr_q && rd_seen;
      trace_rd_wdata  <= rd_val;
      trace_mem_valid <= mem_seen_q;
      trace_mem_addr  <= mem_addr_q;
      trace_mem_we    <= mem_we_q;
    end
  end

endmodule

//--- src/rv_tracer_top.sv
module rv_tracer_top import trace_isa_pkg::*, trace_pipe_pkg::*; #(
  parameter int unsigned XLEN    = DEF_XLEN,
  parameter int unsigned CYCLE_W = DEF_CYCLE_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [XLEN-1:0]       pc,
  input  logic [31:0]           instr,
  input  logic                  id_valid,
  input  logic                  is_decoding,
  input  logic                  pipe_flush,
  input  logic                  ex_valid,
  input  logic [REG_ADDR_W-1:0] ex_reg_addr,
  input  logic                  ex_reg_we,
  input  logic [XLEN-1:0]       ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic [XLEN-1:0]       ex_data_addr,
  input  logic                  ex_data_we,
  input  logic                  wb_bypass,
  input  logic                  wb_valid,
  input  logic [REG_ADDR_W-1:0] wb_reg_addr,
  input  logic                  wb_reg_we,
  input  logic [XLEN-1:0]       wb_reg_wdata,
  output logic                  trace_valid,
  output logic [XLEN-1:0]       trace_pc,
  output logic [31:0]           trace_instr,
  output instr_class_e          trace_class,
  output logic [CYCLE_W-1:0]    trace_cycle,
  output logic [REG_ADDR_W-1:0] trace_rd,
  output logic                  trace_rd_valid,
  output logic [XLEN-1:0]       trace_rd_wdata,
  output logic                  trace_mem_valid,
  output logic [XLEN-1:0]       trace_mem_addr,
  output logic                  trace_mem_we
);

  instr_class_e          id_class;
  logic                  id_rd_wr;
  logic [REG_ADDR_W-1:0] id_rd;
  logic                  capture;
  logic                  ex_busy;
  logic                  ex_leave;
  logic                  wb_retire;
  slot_state_e           wb_state;
  logic [CYCLE_W-1:0]    cycle;

  // record handed from ex to wb
  logic [XLEN-1:0]       rec_pc;
  logic [31:0]           rec_instr;
  instr_class_e          rec_class;
  logic [CYCLE_W-1:0]    rec_cycle;
  logic [REG_ADDR_W-1:0] rec_rd;
  logic                  rec_rd_wr;
  logic [XLEN-1:0]       rec_rd_val;
  logic                  rec_rd_seen;
  logic                  rec_mem_seen;
  logic [XLEN-1:0]       rec_mem_addr;
  logic                  rec_mem_we;

  instr_classifier u_classifier (
    .instr       (instr),
    .instr_class (id_class),
    .rd_wr       (id_rd_wr),
    .rd          (id_rd)
  );

  trace_ctrl #(.CYCLE_W(CYCLE_W)) u_ctrl (
    .clk, .rst_n, .id_valid, .is_decoding, .pipe_flush, .ex_valid, .wb_bypass, .wb_valid,
    .capture, .ex_busy, .ex_leave,
    .wb_busy     (),
    .wb_retire, .wb_state, .cycle
  );

  ex_stage_slot #(.XLEN(XLEN), .CYCLE_W(CYCLE_W)) u_ex_slot (
    .clk, .rst_n, .capture, .ex_busy, .pc, .instr,
    .instr_class (id_class),
    .rd_wr       (id_rd_wr),
    .rd          (id_rd),
    .cycle, .ex_reg_addr, .ex_reg_we, .ex_reg_wdata,
    .ex_data_req, .ex_data_gnt, .ex_data_addr, .ex_data_we,
    .rec_pc, .rec_instr, .rec_class, .rec_cycle, .rec_rd, .rec_rd_wr,
    .rec_rd_val, .rec_rd_seen, .rec_mem_seen, .rec_mem_addr, .rec_mem_we
  );

  wb_stage_slot #(.XLEN(XLEN), .CYCLE_W(CYCLE_W)) u_wb_slot (
    .clk, .rst_n, .ex_leave, .wb_state, .wb_retire,
    .rec_pc, .rec_instr, .rec_class, .rec_cycle, .rec_rd, .rec_rd_wr,
    .rec_rd_val, .rec_rd_seen, .rec_mem_seen, .rec_mem_addr, .rec_mem_we,
    .wb_reg_addr, .wb_reg_we, .wb_reg_wdata,
    .trace_valid, .trace_pc, .trace_instr, .trace_class, .trace_cycle,
    .trace_rd, .trace_rd_valid, .trace_rd_wdata,
    .trace_mem_valid, .trace_mem_addr, .trace_mem_we
  );

endmodule

//--- testbench/tb_rv_tracer.sv
module tb_rv_tracer import trace_isa_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INSTR     = 300;
  localparam int N_TEMPLATES   = 21;
  localparam int ISSUE_TIMEOUT = 20000;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int QUEUE_TIMEOUT = 50;

  // one traced instruction as the model expects it
  typedef struct packed {
    logic [31:0]  pc;
    logic [31:0]  instr;
    instr_class_e cls;
    logic [31:0]  cycle;
    logic [4:0]   rd;
    logic         rd_wr;
    logic         rd_seen;
    logic [31:0]  rd_val;
    logic         mem_seen;
    logic [31:0]  mem_addr;
    logic         mem_we;
  } trace_rec_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic [31:0]  pc;
  logic [31:0]  instr;
  logic         id_valid;
  logic         is_decoding;
  logic         pipe_flush;
  logic         ex_valid;
  logic [4:0]   ex_reg_addr;
  logic         ex_reg_we;
  logic [31:0]  ex_reg_wdata;
  logic         ex_data_req;
  logic         ex_data_gnt;
  logic [31:0]  ex_data_addr;
  logic         ex_data_we;
  logic         wb_bypass;
  logic         wb_valid;
  logic [4:0]   wb_reg_addr;
  logic         wb_reg_we;
  logic [31:0]  wb_reg_wdata;
  logic         trace_valid;
  logic [31:0]  trace_pc;
  logic [31:0]  trace_instr;
  instr_class_e trace_class;
  logic [31:0]  trace_cycle;
  logic [4:0]   trace_rd;
  logic         trace_rd_valid;
  logic [31:0]  trace_rd_wdata;
  logic         trace_mem_valid;
  logic [31:0]  trace_mem_addr;
  logic         trace_mem_we;

  logic [31:0]  lfsr_state = 32'd67042;
  trace_rec_t   exp_q[$];
  trace_rec_t   exp_rec;
  trace_rec_t   ex_rec = '0;
  trace_rec_t   wb_rec = '0;
  logic         ex_full = 1'b0;
  logic         wb_full = 1'b0;
  logic         wb_done = 1'b0;
  int           next_edge = 0;
  int           issued = 0;
  int           cyc;
  int           records = 0;
  int           mismatches = 0;
  int           other_errors = 0;

  rv_tracer_top #(.XLEN(32), .CYCLE_W(32)) u_dut (.*);

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////

  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // reference decode
  ////////////////////////////////////////

  function automatic instr_class_e ref_classify(input logic [31:0] ins, output logic wr);
    logic [6:0]   op;
    logic [2:0]   f3;
    logic [6:0]   f7;
    instr_class_e c;
    op = ins[6:0];
    f3 = ins[14:12];
    f7 = ins[31:25];
    c  = CLS_INVALID;
    if (op[1:0] == 2'b11) begin
      case (op)
        OPC_LUI:      c = CLS_LUI;
        OPC_AUIPC:    c = CLS_AUIPC;
        OPC_JAL:      c = CLS_JAL;
        OPC_JALR:     c = CLS_JALR;
        OPC_MISC_MEM: c = CLS_FENCE;
        OPC_BRANCH:   c = (f3 == 3'd2 || f3 == 3'd3) ? CLS_INVALID : CLS_BRANCH;
        OPC_LOAD:     c = (f3 == 3'd3 || f3 >= 3'd6) ? CLS_INVALID : CLS_LOAD;
        OPC_STORE:    c = (f3 >= 3'd3) ? CLS_INVALID : CLS_STORE;
        OPC_OP_IMM: begin
          c = CLS_OP_IMM;
          if (f3 == 3'd1 && f7 != 7'h00) c = CLS_INVALID;
          if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) c = CLS_INVALID;
        end
        OPC_OP: begin
          c = CLS_INVALID;
          if (f7 == 7'h00) c = CLS_OP;
          if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) c = CLS_OP;
        end
        OPC_SYSTEM: begin
          if (f3 == 3'd0) c = CLS_SYSTEM;
          else if (f3 != 3'd4) c = CLS_CSR;
        end
        default: c = CLS_INVALID;
      endcase
    end
    wr = (c inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_OP_IMM, CLS_OP, CLS_LOAD,
                    CLS_CSR}) && (ins[11:7] != 5'd0);
    return c;
  endfunction

  // templates 0..11 are legal classes, 12..20 the invalid encodings
  function automatic logic [31:0] make_instr(input int sel);
    logic [31:0] w;
    logic [2:0]  f3;
    w  = take_bits(32);
    f3 = w[14:12];
    case (sel)
      0:  w[6:0] = OPC_LUI;
      1:  w[6:0] = OPC_AUIPC;
      2:  w[6:0] = OPC_JAL;
      3:  w = {w[31:15], 3'b000, w[11:7], OPC_JALR};
      4: begin
        w[6:0] = OPC_BRANCH;
        if (f3 == 3'd2 || f3 == 3'd3) w[14:12] = f3 + 3'd3;
      end
      5: begin
        w[6:0] = OPC_LOAD;
        if (f3 == 3'd3 || f3 >= 3'd6) w[14:12] = f3 & 3'b101;
      end
      6:  w = {w[31:15], 3'(f3 % 3), w[11:7], OPC_STORE};
      7: begin
        w[6:0] = OPC_OP_IMM;
        if (f3 == 3'd1) w[31:25] = 7'h00;
        if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
      end
      8: begin
        w[6:0]   = OPC_OP;
        w[31:25] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? w[30] : 1'b0, 5'b0};
      end
      9:  w[6:0] = OPC_MISC_MEM;
      10: begin
        w[6:0] = OPC_SYSTEM;
        if (f3 == 3'd0 || f3 == 3'd4) w[14:12] = f3 | 3'b001;
      end
      11: w = {w[31:15], 3'b000, w[11:7], OPC_SYSTEM};
      12: w[1:0] = {1'b0, w[0]};
      13: w = {w[31:15], 2'b01, w[12], w[11:7], OPC_BRANCH};
      14: w = {w[31:15], w[12] ? 3'b011 : {2'b11, w[13]}, w[11:7], OPC_LOAD};
      15: w = {w[31:15], (f3 < 3'd3) ? f3 + 3'd3 : f3, w[11:7], OPC_STORE};
      16: begin
        // either an M-extension funct7 or the alternate funct7 on a plain op
        w[6:0] = OPC_OP;
        if (w[31]) begin
          w[31:25] = 7'h20;
          if (f3 == 3'd0 || f3 == 3'd5) w[14:12] = f3 + 3'd1;
        end else begin
          w[31:25] = 7'h01;
        end
      end
      17: w = {w[31:26], 1'b1, w[24:15], 3'b001, w[11:7], OPC_OP_IMM};
      18: w = {w[31:26], 1'b1, w[24:15], 3'b101, w[11:7], OPC_OP_IMM};
      19: w = {w[31:15], 3'b100, w[11:7], OPC_SYSTEM};
      default: w[6:0] = w[31] ? 7'b0001011 : 7'b1010111;
    endcase
    return w;
  endfunction

  ////////////////////////////////////////
  // core model called once per cycle
  ////////////////////////////////////////

  // drives the inputs for the next rising edge and updates the model slots
  task automatic drive_cycle(input bit allow_issue);
    logic        retire_now;
    logic        leave_now;
    logic        bypass_now;
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
    logic        req;
    logic        gnt;
    logic        mwe;
    logic        flush;
    logic        sel_bit;
    logic        wr;
    logic [31:0] new_instr;
    logic [31:0] new_pc;
    // bypassed records leave wb without wb_valid
    retire_now = wb_full && (wb_done || take_bits(1));
    we   = take_bit();
    addr = take_bit() ? wb_rec.rd : 5'(take_bits(5));
    data = take_bits(32);
    wb_valid     <= retire_now && !wb_done;
    wb_reg_we    <= we;
    wb_reg_addr  <= addr;
    wb_reg_wdata <= data;
    if (wb_full && !wb_done && we && addr == wb_rec.rd) begin
      wb_rec.rd_val  = data;
      wb_rec.rd_seen = 1'b1;
    end
    if (retire_now) begin
      exp_q.push_back(wb_rec);
      wb_full = 1'b0;
    end
    // ex stage writes and data accesses
    we   = take_bit();
    addr = take_bit() ? ex_rec.rd : 5'(take_bits(5));
    data = take_bits(32);
    ex_reg_we    <= we;
    ex_reg_addr  <= addr;
    ex_reg_wdata <= data;
    if (ex_full && we && addr == ex_rec.rd) begin
      ex_rec.rd_val  = data;
      ex_rec.rd_seen = 1'b1;
    end
    req  = ex_full && (ex_rec.cls == CLS_LOAD || ex_rec.cls == CLS_STORE) && take_bits(1);
    gnt  = req && take_bits(1);
    data = take_bits(32);
    mwe  = ex_rec.mem_seen ? take_bit() : (ex_rec.cls == CLS_STORE);
    ex_data_req  <= req;
    ex_data_gnt  <= gnt;
    ex_data_addr <= data;
    ex_data_we   <= mwe;
    if (gnt && !ex_rec.mem_seen) begin
      ex_rec.mem_seen = 1'b1;
      ex_rec.mem_addr = data;
      ex_rec.mem_we   = mwe;
    end
    leave_now  = ex_full && !wb_full && take_bits(1);
    bypass_now = leave_now && take_bits(1);
    ex_valid  <= leave_now && !bypass_now;
    wb_bypass <= bypass_now;
    if (leave_now) begin
      wb_rec  = ex_rec;
      wb_full = 1'b1;
      wb_done = bypass_now;
      ex_full = 1'b0;
    end
    // a capture needs a free ex slot after this edge
    new_instr = make_instr((issued < N_TEMPLATES) ? issued : take_bits(5) % N_TEMPLATES);
    new_pc    = take_bits(30) << 2;
    pc    <= new_pc;
    instr <= new_instr;
    if (allow_issue && !ex_full && take_bits(1)) begin
      flush = (take_bits(3) == 3'd0);
      pipe_flush  <= flush;
      id_valid    <= !flush || take_bits(1);
      is_decoding <= !flush;
      ex_rec       = '0;
      ex_rec.pc    = new_pc;
      ex_rec.instr = new_instr;
      ex_rec.cls   = ref_classify(new_instr, wr);
      ex_rec.rd_wr = wr;
      ex_rec.rd    = new_instr[11:7];
      ex_rec.cycle = next_edge;
      ex_full      = 1'b1;
      issued++;
    end else begin
      sel_bit = take_bit();
      pipe_flush  <= 1'b0;
      id_valid    <= sel_bit;
      is_decoding <= !sel_bit && take_bits(1);
    end
    next_edge++;
  endtask

  ////////////////////////////////////////
  // comparison
  ////////////////////////////////////////

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      mismatches++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // trace outputs are compared on the falling edge
  always @(negedge clk) begin
    if (trace_valid === 1'b1) begin
      if (!rst_n) begin
        other_errors++;
        $display("trace_valid went high at %0t while reset was asserted", $time);
      end else if (exp_q.size() == 0) begin
        other_errors++;
        $display("trace_valid at %0t without any expected record", $time);
      end else begin
        exp_rec = exp_q.pop_front();
        records++;
        check_field("trace_pc", exp_rec.pc, trace_pc);
        check_field("trace_instr", exp_rec.instr, trace_instr);
        check_field("trace_class", exp_rec.cls, trace_class);
        check_field("trace_cycle", exp_rec.cycle, trace_cycle);
        check_field("trace_rd_valid", exp_rec.rd_wr && exp_rec.rd_seen, trace_rd_valid);
        if (exp_rec.rd_wr && exp_rec.rd_seen) begin
          check_field("trace_rd", exp_rec.rd, trace_rd);
          check_field("trace_rd_wdata", exp_rec.rd_val, trace_rd_wdata);
        end
        check_field("trace_mem_valid", exp_rec.mem_seen, trace_mem_valid);
        if (exp_rec.mem_seen) begin
          check_field("trace_mem_addr", exp_rec.mem_addr, trace_mem_addr);
          check_field("trace_mem_we", exp_rec.mem_we, trace_mem_we);
        end
      end
    end else if (trace_valid !== 1'b0) begin
      other_errors++;
      $display("trace_valid is unknown at %0t", $time);
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    pc           = '0;
    instr        = '0;
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    pipe_flush   = 1'b0;
    ex_valid     = 1'b0;
    ex_reg_addr  = '0;
    ex_reg_we    = 1'b0;
    ex_reg_wdata = '0;
    ex_data_req  = 1'b0;
    ex_data_gnt  = 1'b0;
    ex_data_addr = '0;
    ex_data_we   = 1'b0;
    wb_bypass    = 1'b0;
    wb_valid     = 1'b0;
    wb_reg_addr  = '0;
    wb_reg_we    = 1'b0;
    wb_reg_wdata = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    cyc = 0;
    while (issued < NUM_INSTR && cyc < ISSUE_TIMEOUT) begin
      drive_cycle(1'b1);
      @(posedge clk);
      cyc++;
    end
    if (issued < NUM_INSTR) begin
      other_errors++;
      $display("timed out with only %0d of %0d instructions issued", issued, NUM_INSTR);
    end

    // let the last records leave both stages
    cyc = 0;
    while ((ex_full || wb_full) && cyc < DRAIN_TIMEOUT) begin
      drive_cycle(1'b0);
      @(posedge clk);
      cyc++;
    end
    if (ex_full || wb_full) begin
      other_errors++;
      $display("timed out while draining the core model");
    end

    cyc = 0;
    while ((exp_q.size() != 0 || cyc < 4) && cyc < QUEUE_TIMEOUT) begin
      drive_cycle(1'b0);
      @(posedge clk);
      cyc++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected records never appeared on the trace port", exp_q.size());
    end

    $display("records checked %0d, mismatches %0d, other errors %0d",
             records, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/trace_isa_pkg.sv
src/trace_pipe_pkg.sv
src/instr_classifier.sv
src/trace_ctrl.sv
src/ex_stage_slot.sv
src/wb_stage_slot.sv
src/rv_tracer_top.sv
testbench/tb_rv_tracer.sv
